/* cam_pkg.sv */
`default_nettype none

package cam_pkg;

  ////////////////////
  // blob coordinates

  localparam int coord_w = 10;
  localparam logic [coord_w-1:0] no_blob = coord_w'(1023);  // camera sees nothing

  localparam int cam_x_span = 1024;  // sensor x range
  localparam int cam_y_span = 768;   // sensor y range

  ////////////////////
  // i2c bus and camera registers

  localparam logic [6:0] cam_addr = 7'h58;
  localparam int         i2c_div  = 25;  // clk per quarter scl bit

  // register/value pairs written once after reset
  localparam int init_len = 6;
  localparam logic [0:init_len-1][15:0] init_table = '{
    16'h3001,
    16'h3008,
    16'h0690,
    16'h08c0,
    16'h1a40,
    16'h3333
  };

  localparam logic [7:0] data_reg = 8'h36;  // blob data register
  localparam int         read_len = 3;      // x lo, y lo, packed high bits

endpackage

`default_nettype wire

/* vid_pkg.sv */
`default_nettype none

package vid_pkg;

  ////////////////////
  // 640x480 horizontal timing, in pixels

  localparam int h_active     = 640;
  localparam int h_sync_start = 656;
  localparam int h_sync_end   = 752;
  localparam int h_total      = 800;

  ////////////////////
  // vertical timing, in lines

  localparam int v_active     = 480;
  localparam int v_sync_start = 490;
  localparam int v_sync_end   = 492;
  localparam int v_total      = 525;

  localparam int h_cnt_w = $clog2(h_total);
  localparam int v_cnt_w = $clog2(v_total);
  localparam int cmp_w   = 12;  // room for counter plus dot_half

  // pixel colour and overlay
  localparam int color_w  = 3;
  localparam int dot_half = 4;  // square is 2*dot_half+1 wide

endpackage

`default_nettype wire

/* clk_divn.sv */
`timescale 1ns/1ps
`default_nettype none

module clk_divn #(
  parameter int width = 16,
  parameter int n     = 500
) (
  input  logic clk,
  input  logic rst_n,
  output logic tick
);

  logic [width-1:0] cnt;

  // high in the last cycle of every n
  assign tick = (cnt == width'(n - 1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt <= '0;
    end else if (tick) begin
      cnt <= '0;  // wrap
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

endmodule

`default_nettype wire

/* camera.sv */
`timescale 1ns/1ps
`default_nettype none

module camera (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        i2c_tick,
  input  logic                        start,
  input  logic                        i2c_sda_in,
  output logic                        i2c_scl,
  output logic                        i2c_sda_out,
  output logic                        i2c_sda_dir,
  output logic [cam_pkg::coord_w-1:0] x,
  output logic [cam_pkg::coord_w-1:0] y,
  output logic                        xy_valid
);
  import cam_pkg::*;

  typedef enum logic [1:0] {st_idle, st_start, st_bit, st_stop} bus_state_t;
  typedef enum logic [1:0] {seq_init, seq_wreg, seq_read} seq_state_t;

  bus_state_t                      bus_state;
  seq_state_t                      seq_state;
  logic [1:0]                      quarter;     // quarter of the scl bit
  logic [3:0]                      bit_idx;     // 0..7 data, 8 ack
  logic [2:0]                      byte_idx;
  logic [2:0]                      last_byte;
  logic [2:0]                      sel_idx;
  logic [$clog2(init_len+1)-1:0]   init_idx;
  logic [15:0]                     init_entry;
  logic [7:0]                      next_byte;
  logic [7:0]                      shift;
  logic [23:0]                     rx_data;     // three read bytes, first on top
  logic                            nack;
  logic                            failed;
  logic                            load_xy;
  logic                            is_read;
  logic                            tx_byte;
  logic                            bit_sample;
  logic                            byte_load;

  assign is_read   = (seq_state == seq_read);
  assign tx_byte   = !is_read || (byte_idx == 3'd0);  // master drives this byte
  assign last_byte = is_read ? 3'(read_len) : ((seq_state == seq_init) ? 3'd2 : 3'd1);

  ////////////////////
  // byte to send next

  always_comb begin
    init_entry = init_table[0];
    if (init_idx < init_len) begin
      init_entry = init_table[init_idx];
    end
  end

  assign sel_idx = (bus_state == st_bit) ? byte_idx + 3'd1 : 3'd0;

  always_comb begin
    case (sel_idx)
      3'd0:    next_byte = {cam_addr, is_read};  // address header
      3'd1:    next_byte = (seq_state == seq_init) ? init_entry[15:8] : data_reg;
      default: next_byte = init_entry[7:0];
    endcase
  end

  ////////////////////
  // data shifter

  assign bit_sample = i2c_tick && (bus_state == st_bit) && (quarter == 2'd2);
  assign byte_load  = i2c_tick && (quarter == 2'd3) &&
                      ((bus_state == st_start) || ((bus_state == st_bit) && (bit_idx == 4'd8)));

  always_ff @(posedge clk) begin
    if (byte_load) begin
      shift <= next_byte;
    end else if (bit_sample && (bit_idx < 4'd8)) begin
      shift <= {shift[6:0], tx_byte ? 1'b0 : i2c_sda_in};  // msb first
    end
    if (bit_sample && (bit_idx == 4'd8) && !tx_byte) begin
      rx_data <= {rx_data[15:0], shift};
    end
  end

  ////////////////////
  // bus phases and sequence

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      bus_state   <= st_idle;
      seq_state   <= seq_init;
      quarter     <= 2'd0;
      bit_idx     <= 4'd0;
      byte_idx    <= 3'd0;
      init_idx    <= '0;
      nack        <= 1'b0;
      failed      <= 1'b0;
      load_xy     <= 1'b0;
      i2c_scl     <= 1'b1;
      i2c_sda_out <= 1'b1;
      i2c_sda_dir <= 1'b0;
      x           <= no_blob;
      y           <= no_blob;
      xy_valid    <= 1'b0;
    end else begin
      xy_valid <= load_xy;
      load_xy  <= 1'b0;
      if (load_xy) begin
        x <= {rx_data[5:4], rx_data[23:16]};
        y <= {rx_data[7:6], rx_data[15:8]};
      end

      if (i2c_tick) begin
        case (bus_state)
          st_idle: begin
            i2c_scl     <= 1'b1;
            i2c_sda_dir <= 1'b0;
            if (start) begin
              bus_state <= st_start;
              quarter   <= 2'd0;
              byte_idx  <= 3'd0;
              failed    <= 1'b0;
            end
          end

          st_start: begin
            quarter <= quarter + 2'd1;
            case (quarter)
              2'd0: begin
                i2c_sda_dir <= 1'b1;
                i2c_sda_out <= 1'b1;
              end
              2'd1: i2c_sda_out <= 1'b0;  // sda falls while scl high
              2'd2: i2c_scl <= 1'b0;
              default: begin
                bus_state <= st_bit;
                bit_idx   <= 4'd0;
              end
            endcase
          end

          st_bit: begin
            quarter <= quarter + 2'd1;
            case (quarter)
              2'd0: begin
                if (bit_idx < 4'd8) begin
                  i2c_sda_dir <= tx_byte;
                  i2c_sda_out <= shift[7];
                end else begin
                  i2c_sda_dir <= !tx_byte;                   // we ack read bytes
                  i2c_sda_out <= (byte_idx == last_byte);    // nack the last one
                end
              end
              2'd1: i2c_scl <= 1'b1;
              2'd2: begin
                if ((bit_idx == 4'd8) && tx_byte) begin
                  nack <= i2c_sda_in;
                end
              end
              default: begin
                i2c_scl <= 1'b0;
                if (bit_idx != 4'd8) begin
                  bit_idx <= bit_idx + 4'd1;
                end else if ((tx_byte && nack) || (byte_idx == last_byte)) begin
                  bus_state <= st_stop;
                  failed    <= tx_byte && nack;  // abort, step is retried
                end else begin
                  byte_idx <= byte_idx + 3'd1;
                  bit_idx  <= 4'd0;
                end
              end
            endcase
          end

          default: begin
            quarter <= quarter + 2'd1;
            case (quarter)
              2'd0: begin
                i2c_sda_dir <= 1'b1;
                i2c_sda_out <= 1'b0;
              end
              2'd1: i2c_scl <= 1'b1;
              2'd2: begin
                i2c_sda_dir <= 1'b0;  // sda rises, stop condition
                if (!failed && is_read) begin
                  load_xy <= 1'b1;
                end
              end
              default: begin
                bus_state <= st_idle;
                if (!failed) begin
                  case (seq_state)
                    seq_init: begin
                      init_idx <= init_idx + 1'b1;
                      if (init_idx == init_len - 1) begin
                        seq_state <= seq_wreg;
                      end
                    end
                    seq_wreg: seq_state <= seq_read;
                    default:  seq_state <= seq_wreg;  // loop forever
                  endcase
                end
              end
            endcase
          end
        endcase
      end
    end
  end

endmodule

`default_nettype wire

/* xy_leds.sv */
`timescale 1ns/1ps
`default_nettype none

module xy_leds (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic [cam_pkg::coord_w-1:0] x,
  input  logic [cam_pkg::coord_w-1:0] y,
  output logic [3:0]                  led
);
  import cam_pkg::*;

  logic       right;
  logic       bottom;
  logic       no_dot;
  logic [1:0] quadrant;

  assign right    = (x >= coord_w'(cam_x_span / 2));
  assign bottom   = (y >= coord_w'(cam_y_span / 2));
  assign no_dot   = (x == no_blob) || (y == no_blob);
  assign quadrant = {bottom, right};  // 0 tl, 1 tr, 2 bl, 3 br

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      led <= 4'b0000;
    end else if (no_dot) begin
      led <= 4'b0000;  // nothing tracked
    end else begin
      led <= 4'b0001 << quadrant;
    end
  end

endmodule

`default_nettype wire

/* vga.sv */
`timescale 1ns/1ps
`default_nettype none

module vga (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic [cam_pkg::coord_w-1:0] x,
  input  logic [cam_pkg::coord_w-1:0] y,
  output logic                        hsync,
  output logic                        vsync,
  output logic                        blank,
  output logic [vid_pkg::color_w-1:0] red,
  output logic [vid_pkg::color_w-1:0] green,
  output logic [vid_pkg::color_w-1:0] blue
);
  import cam_pkg::*;
  import vid_pkg::*;

  logic [h_cnt_w-1:0] h_cnt;
  logic [v_cnt_w-1:0] v_cnt;
  logic [coord_w+2:0] x_scaled;
  logic [coord_w+2:0] y_scaled;
  logic [coord_w-1:0] sx;
  logic [coord_w-1:0] sy;
  logic               dot_en;
  logic               frame_start;
  logic               active;
  logic               in_x;
  logic               in_y;
  logic [cmp_w-1:0]   h_ext;
  logic [cmp_w-1:0]   v_ext;
  logic [cmp_w-1:0]   sx_ext;
  logic [cmp_w-1:0]   sy_ext;

  ////////////////////
  // raster counters

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      h_cnt <= '0;
      v_cnt <= '0;
    end else if (h_cnt == h_cnt_w'(h_total - 1)) begin
      h_cnt <= '0;
      if (v_cnt == v_cnt_w'(v_total - 1)) begin
        v_cnt <= '0;
      end else begin
        v_cnt <= v_cnt + 1'b1;
      end
    end else begin
      h_cnt <= h_cnt + 1'b1;
    end
  end

  ////////////////////
  // dot position, latched per frame

  assign frame_start = (h_cnt == '0) && (v_cnt == '0);
  assign x_scaled    = ({3'b000, x} << 2) + {3'b000, x};  // x*5
  assign y_scaled    = ({3'b000, y} << 2) + {3'b000, y};

  always_ff @(posedge clk) begin
    if (frame_start) begin
      sx <= x_scaled[coord_w+2:3];  // /8 gives 5/8 scale
      sy <= y_scaled[coord_w+2:3];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dot_en <= 1'b0;
    end else if (frame_start) begin
      dot_en <= (x != no_blob) && (y != no_blob);
    end
  end

  // within dot_half of the centre on both axes
  assign h_ext  = cmp_w'(h_cnt);
  assign v_ext  = cmp_w'(v_cnt);
  assign sx_ext = cmp_w'(sx);
  assign sy_ext = cmp_w'(sy);
  assign in_x   = (h_ext + cmp_w'(dot_half) >= sx_ext) && (h_ext <= sx_ext + cmp_w'(dot_half));
  assign in_y   = (v_ext + cmp_w'(dot_half) >= sy_ext) && (v_ext <= sy_ext + cmp_w'(dot_half));
  assign active = (h_cnt < h_cnt_w'(h_active)) && (v_cnt < v_cnt_w'(v_active));

  ////////////////////
  // registered outputs

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      hsync <= 1'b1;
      vsync <= 1'b1;
      blank <= 1'b1;
      red   <= '0;
      green <= '0;
      blue  <= '0;
    end else begin
      hsync <= !((h_cnt >= h_cnt_w'(h_sync_start)) && (h_cnt < h_cnt_w'(h_sync_end)));
      vsync <= !((v_cnt >= v_cnt_w'(v_sync_start)) && (v_cnt < v_cnt_w'(v_sync_end)));
      blank <= !active;
      if (active && dot_en && in_x && in_y) begin
        red   <= '1;  // white square
        green <= '1;
        blue  <= '1;
      end else begin
        red   <= '0;
        green <= '0;
        blue  <= '0;
      end
    end
  end

endmodule

`default_nettype wire

/* ir_tracker_top.sv */
`timescale 1ns/1ps
`default_nettype none

module ir_tracker_top (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        start,
  input  logic                        i2c_sda_in,
  output logic                        i2c_scl,
  output logic                        i2c_sda_out,
  output logic                        i2c_sda_dir,
  output logic                        pixart_reset,
  output logic [3:0]                  led,
  output logic                        hsync,
  output logic                        vsync,
  output logic                        blank,
  output logic [vid_pkg::color_w-1:0] red,
  output logic [vid_pkg::color_w-1:0] green,
  output logic [vid_pkg::color_w-1:0] blue
);
  import cam_pkg::*;

  logic               i2c_tick;
  logic [coord_w-1:0] x;
  logic [coord_w-1:0] y;

  assign pixart_reset = 1'b1;  // camera kept out of reset

  // quarter-bit enable for the i2c master
  clk_divn #(
    .width ($clog2(i2c_div)),
    .n     (i2c_div)
  ) u_i2c_div (
    .clk   (clk),
    .rst_n (rst_n),
    .tick  (i2c_tick)
  );

  camera u_cam (
    .clk         (clk),
    .rst_n       (rst_n),
    .i2c_tick    (i2c_tick),
    .start       (start),
    .i2c_sda_in  (i2c_sda_in),
    .i2c_scl     (i2c_scl),
    .i2c_sda_out (i2c_sda_out),
    .i2c_sda_dir (i2c_sda_dir),
    .x           (x),
    .y           (y),
    .xy_valid    ()  // leds and vga follow x/y directly
  );

  xy_leds u_leds (
    .clk   (clk),
    .rst_n (rst_n),
    .x     (x),
    .y     (y),
    .led   (led)
  );

  // pixel clock is clk itself
  vga u_vga (
    .clk   (clk),
    .rst_n (rst_n),
    .x     (x),
    .y     (y),
    .hsync (hsync),
    .vsync (vsync),
    .blank (blank),
    .red   (red),
    .green (green),
    .blue  (blue)
  );

endmodule

`default_nettype wire

/* cam_i2c_model.sv */
`timescale 1ns/1ps
`default_nettype none

module cam_i2c_model (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        scl,
  input  logic        sda,
  input  logic        nack_next,   // refuse the next address
  input  logic [7:0]  rd_b0,
  input  logic [7:0]  rd_b1,
  input  logic [7:0]  rd_b2,
  output logic        sda_low,     // pull-down on the shared line
  output logic        wr_stb,
  output logic [7:0]  wr_byte,
  output logic        addr_nack,
  output logic        busy,
  output logic [31:0] start_cnt,
  output logic [31:0] reads_done
);

  logic       prev_scl;
  logic       prev_sda;
  logic       is_addr;
  logic       reading;
  logic       m_nack;   // master ack bit of a read byte
  logic [3:0] bit_cnt;
  logic [1:0] rd_idx;
  logic [7:0] sh;
  logic [7:0] tx;
  logic [7:0] next_tx;

  always_comb begin
    case (rd_idx)
      2'd0:    next_tx = rd_b0;
      2'd1:    next_tx = rd_b1;
      default: next_tx = rd_b2;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      prev_scl   <= 1'b1;
      prev_sda   <= 1'b1;
      is_addr    <= 1'b0;
      reading    <= 1'b0;
      m_nack     <= 1'b0;
      bit_cnt    <= 4'd0;
      rd_idx     <= 2'd0;
      sh         <= 8'h00;
      tx         <= 8'hff;
      sda_low    <= 1'b0;
      wr_stb     <= 1'b0;
      wr_byte    <= 8'h00;
      addr_nack  <= 1'b0;
      busy       <= 1'b0;
      start_cnt  <= '0;
      reads_done <= '0;
    end else begin
      prev_scl  <= scl;
      prev_sda  <= sda;
      wr_stb    <= 1'b0;
      addr_nack <= 1'b0;
      if (prev_scl && scl && prev_sda && !sda) begin  // start
        busy      <= 1'b1;
        start_cnt <= start_cnt + 1;
        bit_cnt   <= 4'd0;
        is_addr   <= 1'b1;
        reading   <= 1'b0;
        rd_idx    <= 2'd0;
        sda_low   <= 1'b0;
      end else if (prev_scl && scl && !prev_sda && sda) begin  // stop
        busy    <= 1'b0;
        sda_low <= 1'b0;
        reading <= 1'b0;
        if (reading) begin
          reads_done <= reads_done + 1;
        end
      end else if (busy && !prev_scl && scl) begin  // scl rise
        if (bit_cnt < 4'd8) begin
          if (!(reading && !is_addr)) begin
            sh <= {sh[6:0], sda};
          end
        end else begin
          m_nack <= sda;
        end
        bit_cnt <= bit_cnt + 4'd1;
      end else if (busy && prev_scl && !scl) begin  // scl fall
        if (bit_cnt == 4'd8) begin
          if (reading && !is_addr) begin
            sda_low <= 1'b0;  // master acks
          end else begin
            wr_byte <= sh;
            wr_stb  <= 1'b1;
            if (is_addr) begin
              reading   <= sh[0] && !nack_next;
              addr_nack <= nack_next;
              sda_low   <= !nack_next;
            end else begin
              sda_low <= 1'b1;
            end
          end
        end else if (bit_cnt == 4'd9) begin
          bit_cnt <= 4'd0;
          is_addr <= 1'b0;
          if (reading && !(m_nack && !is_addr)) begin
            tx      <= next_tx;
            sda_low <= !next_tx[7];
            rd_idx  <= rd_idx + 2'd1;
          end else begin
            sda_low <= 1'b0;
          end
        end else if ((bit_cnt != 4'd0) && reading && !is_addr) begin
          sda_low <= !tx[3'(4'd7 - bit_cnt)];  // msb first
        end
      end
    end
  end

endmodule

`default_nettype wire

/* tb_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_top;
  import cam_pkg::*;
  import vid_pkg::*;

  localparam int frame_clks = h_total * v_total;

  logic               clk;
  logic               rst_n;
  logic               start;
  logic               sda;
  logic               i2c_scl;
  logic               i2c_sda_out;
  logic               i2c_sda_dir;
  logic               pixart_reset;
  logic [3:0]         led;
  logic               hsync;
  logic               vsync;
  logic               blank;
  logic [color_w-1:0] red;
  logic [color_w-1:0] green;
  logic [color_w-1:0] blue;
  logic               sda_low;
  logic               wr_stb;
  logic [7:0]         wr_byte;
  logic               addr_nack;
  logic               model_busy;
  logic [31:0]        start_cnt;
  logic [31:0]        reads_done;
  logic               nack_next;
  logic [7:0]         rd_b0;
  logic [7:0]         rd_b1;
  logic [7:0]         rd_b2;
  logic [7:0]         wr_q[$];
  int                 nack_idx;
  int                 errors;
  int                 tests;

  // open drain line, pulled up
  assign sda = (i2c_sda_dir ? i2c_sda_out : 1'b1) & !sda_low;

  ir_tracker_top u_dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .start        (start),
    .i2c_sda_in   (sda),
    .i2c_scl      (i2c_scl),
    .i2c_sda_out  (i2c_sda_out),
    .i2c_sda_dir  (i2c_sda_dir),
    .pixart_reset (pixart_reset),
    .led          (led),
    .hsync        (hsync),
    .vsync        (vsync),
    .blank        (blank),
    .red          (red),
    .green        (green),
    .blue         (blue)
  );

  cam_i2c_model u_model (
    .clk        (clk),
    .rst_n      (rst_n),
    .scl        (i2c_scl),
    .sda        (sda),
    .nack_next  (nack_next),
    .rd_b0      (rd_b0),
    .rd_b1      (rd_b1),
    .rd_b2      (rd_b2),
    .sda_low    (sda_low),
    .wr_stb     (wr_stb),
    .wr_byte    (wr_byte),
    .addr_nack  (addr_nack),
    .busy       (model_busy),
    .start_cnt  (start_cnt),
    .reads_done (reads_done)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // every byte the master wrote
  always @(posedge clk) begin
    if (wr_stb) begin
      if (addr_nack) begin
        nack_idx = wr_q.size();
      end
      wr_q.push_back(wr_byte);
    end
  end

  ////////////////////
  // compare tasks

  task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_level(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_coord(input logic [coord_w-1:0] got, input logic [coord_w-1:0] exp,
                             input string what);
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t: %s got %0d expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_led(input logic [3:0] got, input logic [3:0] exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_pixel(input logic [color_w-1:0] r, input logic [color_w-1:0] g,
                             input logic [color_w-1:0] b, input logic [color_w-1:0] exp,
                             input string what);
    if ((r !== exp) || (g !== exp) || (b !== exp)) begin
      errors++;
      $display("Mismatch at %0t: %s got %h/%h/%h expected %h", $time, what, r, g, b, exp);
    end
  endtask

  task automatic check_count(input int got, input int exp, input string what);
    if (got != exp) begin
      errors++;
      $display("Mismatch at %0t: %s got %0d expected %0d", $time, what, got, exp);
    end
  endtask

  ////////////////////
  // waits, each bounded

  task automatic wait_clks(input int n);
    for (int i = 0; i < n; i++) begin
      @(posedge clk);
    end
  endtask

  task automatic wait_bytes(input int n, output bit ok);
    int t;
    t = 0;
    while ((wr_q.size() < n) && (t < 60000)) begin
      @(posedge clk);
      t++;
    end
    ok = (wr_q.size() >= n);
    if (!ok) begin
      errors++;
      $display("Timeout at %0t: only %0d of %0d I2C bytes written", $time, wr_q.size(), n);
    end
  endtask

  task automatic wait_reads(input int n, output bit ok);
    int t;
    t = 0;
    while ((int'(reads_done) < n) && (t < 40000)) begin
      @(posedge clk);
      t++;
    end
    ok = (int'(reads_done) >= n);
    if (!ok) begin
      errors++;
      $display("Timeout at %0t: camera reads did not complete", $time);
    end
  endtask

  task automatic wait_led_change(input logic [3:0] prev, output bit ok);
    int t;
    t = 0;
    while ((led === prev) && (t < 400)) begin
      @(posedge clk);
      t++;
    end
    ok = (led !== prev);
    if (!ok) begin
      errors++;
      $display("Timeout at %0t: led never changed from %b", $time, prev);
    end
  endtask

  task automatic wait_idle(output bit ok);
    int t;
    t = 0;
    while (model_busy && (t < 20000)) begin
      @(posedge clk);
      t++;
    end
    ok = !model_busy;
    if (!ok) begin
      errors++;
      $display("Timeout at %0t: I2C transfer never ended", $time);
    end
  endtask

  function automatic void next_pixel(inout int h, inout int v);
    h++;
    if (h == h_total) begin
      h = 0;
      v = (v == v_total - 1) ? 0 : v + 1;
    end
  endfunction

  ////////////////////
  // one full frame, from pixel 0,0

  task automatic scan_frame(input bit dot, input int sx, input int sy, input bit timing);
    int   t;
    int   h;
    int   v;
    int   white;
    int   hs_low;
    int   vs_low;
    int   lines;
    int   bad_blank;
    bit   found;
    logic prev_vs;
    logic prev_hs;
    t       = 0;
    found   = 1'b0;
    prev_vs = vsync;
    while (!found && (t < 2 * frame_clks)) begin
      @(negedge clk);
      t++;
      found   = prev_vs && !vsync;
      prev_vs = vsync;
    end
    if (!found) begin
      errors++;
      $display("Timeout at %0t: no vsync pulse seen", $time);
    end else begin
      h = 0;
      v = v_sync_start;  // outputs lag the counters by one clk
      while ((h != 0) || (v != 0)) begin
        @(negedge clk);
        next_pixel(h, v);
      end
      white     = 0;
      hs_low    = 0;
      vs_low    = 0;
      lines     = 0;
      bad_blank = 0;
      prev_hs   = hsync;
      for (int n = 0; n < frame_clks; n++) begin
        if ((red == '1) && (green == '1) && (blue == '1)) begin
          white++;
        end
        if ((v == 0) && !hsync) begin
          hs_low++;
        end
        if (!vsync) begin
          vs_low++;
        end
        if (prev_hs && !hsync) begin
          lines++;
        end
        if (blank !== !((h < h_active) && (v < v_active))) begin
          bad_blank++;
        end
        prev_hs = hsync;
        if (dot && (h == sx) && (v == sy)) begin
          check_pixel(red, green, blue, '1, "dot centre");
        end
        if (dot && (v == sy) && ((h == sx - dot_half - 1) || (h == sx + dot_half + 1))) begin
          check_pixel(red, green, blue, '0, "left or right of dot");
        end
        if (dot && (h == sx) && ((v == sy - dot_half - 1) || (v == sy + dot_half + 1))) begin
          check_pixel(red, green, blue, '0, "above or below dot");
        end
        @(negedge clk);
        next_pixel(h, v);
      end
      check_count(white, dot ? (2 * dot_half + 1) * (2 * dot_half + 1) : 0, "white pixels");
      if (timing) begin
        check_count(hs_low, h_sync_end - h_sync_start, "hsync low clocks");
        check_count(vs_low, (v_sync_end - v_sync_start) * h_total, "vsync low clocks");
        check_count(lines, v_total, "lines per frame");
        check_count(bad_blank, 0, "pixels with wrong blank");
      end
    end
  endtask

  task automatic report_test(input string name, input int err0);
    tests++;
    $display("test %0d %s: %s", tests, name, (errors == err0) ? "ok" : "failed");
  endtask

  // drop start for a random gap; the bus must stay quiet
  task automatic pause_start;
    bit ok;
    int snap;
    int gap;
    @(posedge clk);
    #2 start = 1'b0;
    wait_clks(8 * i2c_div);  // a transfer already begun shows its start
    wait_idle(ok);
    snap = int'(start_cnt);
    gap  = 200 + int'($urandom % 1000);
    wait_clks(gap);
    check_count(int'(start_cnt) - snap, 0, "start conditions while start low");
    @(posedge clk);
    #2 start = 1'b1;
  endtask

  task automatic run_case(input int b0, input int b1, input int b2, input int e_led,
                          input int e_sx, input int e_sy);
    int         err0;
    int         dx;
    int         dy;
    bit         ok;
    bit         dot;
    logic [3:0] prev_led;
    err0     = errors;
    dx       = ((b2 >> 4) & 3) * 256 + b0;  // x hi bits at 5:4
    dy       = ((b2 >> 6) & 3) * 256 + b1;
    dot      = !((e_sx == 'hff) && (e_sy == 'hff));
    prev_led = led;
    @(posedge clk);
    #2;
    rd_b0 = 8'(b0);
    rd_b1 = 8'(b1);
    rd_b2 = 8'(b2);
    wait_reads(int'(reads_done) + 2, ok);  // second read sees only new bytes
    if (ok) begin
      wait_led_change(prev_led, ok);
    end
    if (ok) begin
      check_led(led, 4'(e_led), "quadrant led");
      check_coord(u_dut.x, coord_w'(dx), "decoded x");
      check_coord(u_dut.y, coord_w'(dy), "decoded y");
      scan_frame(dot, e_sx, e_sy, 1'b0);
    end
    pause_start();
    report_test($sformatf("blob at %0d,%0d", dx, dy), err0);
  endtask

  task automatic retry_test;
    int err0;
    int t;
    bit ok;
    err0     = errors;
    nack_idx = -1;
    @(posedge clk);
    #2 nack_next = 1'b1;
    t = 0;
    while ((nack_idx < 0) && (t < 20000)) begin
      @(posedge clk);
      t++;
    end
    #2 nack_next = 1'b0;
    if (nack_idx < 0) begin
      errors++;
      $display("Timeout at %0t: no address was refused", $time);
    end else begin
      wait_bytes(nack_idx + 3, ok);
      if (ok) begin
        check_byte({wr_q[nack_idx][7:1], 1'b0}, {cam_addr, 1'b0}, "refused header");
        check_byte(wr_q[nack_idx + 1], wr_q[nack_idx], "retried header");
        if (wr_q[nack_idx][0] == 1'b0) begin
          check_byte(wr_q[nack_idx + 2], data_reg, "retried register");
        end
      end
    end
    report_test("address nack retry", err0);
  endtask

  ////////////////////
  // main sequence

  initial begin
    int    fd;
    int    n;
    int    err0;
    int    b0;
    int    b1;
    int    b2;
    int    e_led;
    int    e_sx;
    int    e_sy;
    bit    ok;
    string line;
    void'($urandom(32'h2c1e_8630));
    errors    = 0;
    tests     = 0;
    nack_idx  = -1;
    rst_n     = 1'b0;
    start     = 1'b0;
    nack_next = 1'b0;
    rd_b0     = 8'hff;  // no blob until a case loads bytes
    rd_b1     = 8'hff;
    rd_b2     = 8'hf0;
    wait_clks(2);
    #2 rst_n = 1'b1;

    err0 = errors;
    check_led(led, 4'b0000, "led after reset");
    check_level(i2c_sda_dir, 1'b0, "sda direction after reset");
    check_level(i2c_scl, 1'b1, "scl after reset");
    check_level(pixart_reset, 1'b1, "camera reset pin");
    @(posedge clk);
    #2 start = 1'b1;
    wait_bytes(3 * init_len, ok);
    if (ok) begin
      for (int i = 0; i < init_len; i++) begin
        check_byte(wr_q[3 * i], {cam_addr, 1'b0}, "init header");
        check_byte(wr_q[3 * i + 1], init_table[i][15:8], "init register");
        check_byte(wr_q[3 * i + 2], init_table[i][7:0], "init value");
      end
    end
    scan_frame(1'b0, 0, 0, 1'b1);
    report_test("init and raster timing", err0);

    fd = $fopen("ir_tracker_stim.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("Cannot open stimulus file ir_tracker_stim.txt");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        n    = $fgets(line, fd);
        if ((n > 0) && (line.len() > 1) && (line[0] != 8'h23)) begin
          n = $sscanf(line, "%h %h %h %h %h %h", b0, b1, b2, e_led, e_sx, e_sy);
          if (n == 6) begin
            run_case(b0, b1, b2, e_led, e_sx, e_sy);
          end
        end
      end
      $fclose(fd);
    end

    retry_test();

    $display("tests: %0d, errors: %0d", tests, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* ir_tracker_stim.txt */
# columns, all hex: byte0 (x lo) byte1 (y lo) byte2 (y hi 7:6, x hi 5:4)
# then expected led, dot sx, dot sy; sx and sy ff mean no dot
64 64 00 1 3e 3e
20 c8 30 2 1f4 7d
2c 58 90 4 bb 177
e8 bc b0 8 271 1b5
ff ff f0 0 ff ff

/* ir_tracker.f */
cam_pkg.sv
vid_pkg.sv
clk_divn.sv
camera.sv
xy_leds.sv
vga.sv
ir_tracker_top.sv
cam_i2c_model.sv
tb_top.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       ?= tb_top
FLIST     ?= ir_tracker.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "Result: PASSED"

clean:
	rm -rf $(OBJ_DIR)
